//--- exec_core.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/alu1.sv
hdl/reg_file.sv
hdl/muldiv_unit.sv
hdl/wb_arbiter.sv
hdl/issue_ctrl.sv
hdl/exec_core.sv
bench/exec_core_props.sv
bench/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the exec_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	-f exec_core.f --top-module exec_core_tb \
	--Mdir obj_dir -o sim_exec_core; then
	echo "compile step failed"
	exit 1
fi

if ! ./obj_dir/sim_exec_core > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error status"
	exit 1
fi
cat "$LOG"

if grep -q "Verification passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/exec_core_tb.sv
`default_nettype none
`include "exec_params.svh"

module exec_core_tb;
	import exec_pkg::*;

	logic                   clk;
	logic                   reset;
	logic                   issue;
	exec_unit_t             unit;
	alu_op_t                alu_op;
	md_op_t                 md_op;
	logic [`EXEC_RADDR-1:0] rs;
	logic [`EXEC_RADDR-1:0] rt;
	logic [`EXEC_RADDR-1:0] rd;
	logic                   use_imm;
	logic [`EXEC_XLEN-1:0]  imm;
	logic                   busy;
	logic                   wb_valid;
	logic [`EXEC_RADDR-1:0] wb_addr;
	logic [`EXEC_XLEN-1:0]  wb_data;
	logic                   overflow;

	logic [`EXEC_XLEN-1:0] model_regs [`EXEC_NREGS];	// expected register contents
	integer                seed;
	int                    errors;
	int                    timeouts;

	exec_core UUT (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue),
		.unit     (unit),
		.alu_op   (alu_op),
		.md_op    (md_op),
		.rs       (rs),
		.rt       (rt),
		.rd       (rd),
		.use_imm  (use_imm),
		.imm      (imm),
		.busy     (busy),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.overflow (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// trap flag above the result, from the MIPS rules
	function automatic logic [32:0] model_alu(input alu_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		longint      sa;
		longint      sb;
		longint      wide;
		logic [31:0] res;
		logic        ovf;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ovf = 1'b0;
		res = '0;
		case (op)
			alu_add, alu_addu, alu_sub, alu_subu: begin
				wide = ((op == alu_add) || (op == alu_addu)) ? sa + sb : sa - sb;
				res = wide[31:0];
				if ((op == alu_add) || (op == alu_sub)) begin
					ovf = (wide != longint'($signed(res)));	// does not fit in 32 bits
				end
			end
			alu_or:   res = a | b;
			alu_and:  res = a & b;
			alu_nor:  res = ~(a | b);
			alu_xor:  res = a ^ b;
			alu_sll:  res = b << a[4:0];
			alu_srl:  res = b >> a[4:0];
			alu_sra: begin
				res = b;
				for (int i = 0; i < a[4:0]; i++) begin
					res = {res[31], res[31:1]};
				end
			end
			alu_slt:  res = (sa < sb) ? 32'd1 : 32'd0;
			alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
			default:  res = '0;
		endcase
		return {ovf, res};
	endfunction

	function automatic logic [31:0] model_md(input md_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] prod;
		prod = {32'b0, a} * {32'b0, b};
		case (op)
			md_mul:  return prod[31:0];
			md_divu: return (b == '0) ? '1 : a / b;
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	function automatic logic [`EXEC_RADDR-1:0] pick_reg();
		logic [31:0] r;
		r = $random(seed);
		return 5'(r % 8) + 5'd1;	// r1..r8 hold seeded values
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// caller has just passed a rising edge
	task automatic set_issue(input exec_unit_t u, input alu_op_t aop, input md_op_t mop,
		input logic [4:0] s, input logic [4:0] t, input logic [4:0] d,
		input logic sel, input logic [31:0] val);
		issue   <= 1'b1;
		unit    <= u;
		alu_op  <= aop;
		md_op   <= mop;
		rs      <= s;
		rt      <= t;
		rd      <= d;
		use_imm <= sel;
		imm     <= val;
	endtask

	task automatic alu_check(input alu_op_t op, input logic [4:0] s, input logic [4:0] t,
		input logic [4:0] d, input logic sel, input logic [31:0] val);
		logic [32:0] exp;
		exp = model_alu(op, model_regs[s], sel ? val : model_regs[t]);
		@(posedge clk);
		set_issue(unit_alu, op, md_mul, s, t, d, sel, val);
		@(posedge clk);
		issue <= 1'b0;
		@(negedge clk);	// writeback report of that issue
		check_value("overflow", overflow, exp[32]);
		if (exp[32] || (d == '0)) begin
			check_value("wb_valid", wb_valid, 1'b0);
		end else begin
			check_value("wb_valid", wb_valid, 1'b1);
			check_value("wb_addr", wb_addr, d);
			check_value("wb_data", wb_data, exp[31:0]);
			model_regs[d] = exp[31:0];
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && (n < 10)) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			timeouts++;
			$display("Timeout: busy stayed high after the multiply/divide write");
		end
	endtask

	task automatic md_check(input md_op_t op, input logic [4:0] s, input logic [4:0] t,
		input logic [4:0] d);
		logic [31:0] exp;
		logic        done;
		int          n;
		exp = model_md(op, model_regs[s], model_regs[t]);
		@(posedge clk);
		set_issue(unit_md, alu_addu, op, s, t, d, 1'b0, '0);
		n = 0;
		done = 1'b0;
		while (!done && (n < 100)) begin
			@(posedge clk);
			issue <= 1'b0;
			n++;
			@(negedge clk);
			if (n == 1) begin
				check_value("busy", busy, 1'b1);
			end
			done = wb_valid;
		end
		if (!done) begin
			timeouts++;
			$display("Timeout: no multiply/divide writeback to r%0d", d);
		end else begin
			check_value("md latency", n, 34);	// counted from the issue edge
			check_value("md wb_addr", wb_addr, d);
			check_value("md wb_data", wb_data, exp);
			model_regs[d] = exp;
		end
		wait_idle();
	endtask

	task automatic seed_regs();
		for (int i = 1; i <= 8; i++) begin
			alu_check(alu_add, 0, 0, 5'(i), 1'b1, $random(seed));
		end
		alu_check(alu_add, 0, 0, 2, 1'b1, $random(seed) & 32'h7fff_ffff);	// positive
		alu_check(alu_add, 0, 0, 26, 1'b1, 32'd0);
		alu_check(alu_add, 0, 0, 27, 1'b1, 32'd31);
		alu_check(alu_add, 0, 0, 28, 1'b1, $random(seed) | 32'h8000_0000);	// negative
	endtask

	task automatic arith_test();
		alu_op_t ops [6];
		ops = '{alu_addu, alu_subu, alu_or, alu_and, alu_nor, alu_xor};
		for (int i = 0; i < 6; i++) begin
			alu_check(ops[i], pick_reg(), pick_reg(), 5'(9 + i), 1'b0, '0);
			alu_check(ops[i], pick_reg(), 0, 5'(9 + i), 1'b1, $random(seed));
		end
		alu_check(alu_or, 1, 2, 0, 1'b0, '0);	// r0 write not reported
	endtask

	task automatic shift_test();
		alu_op_t ops [3];
		ops = '{alu_sll, alu_srl, alu_sra};
		for (int i = 0; i < 3; i++) begin
			alu_check(ops[i], 26, 28, 16, 1'b0, '0);	// amount 0
			alu_check(ops[i], 27, 28, 16, 1'b0, '0);	// amount 31
			alu_check(ops[i], pick_reg(), 28, 16, 1'b0, '0);
		end
	endtask

	task automatic compare_test();
		alu_check(alu_slt, 28, 2, 17, 1'b0, '0);
		alu_check(alu_sltu, 28, 2, 18, 1'b0, '0);
		alu_check(alu_xor, 17, 18, 19, 1'b0, '0);	// signs differ so the two disagree
		check_value("slt vs sltu", wb_data, 32'd1);
		alu_check(alu_slt, 2, 28, 17, 1'b0, '0);
		alu_check(alu_sltu, 2, 28, 18, 1'b0, '0);
		alu_check(alu_xor, 17, 18, 19, 1'b0, '0);
		check_value("slt vs sltu", wb_data, 32'd1);
	endtask

	task automatic overflow_test();
		alu_check(alu_add, 0, 0, 20, 1'b1, 32'h7000_0000);
		alu_check(alu_add, 0, 0, 21, 1'b1, 32'h6000_0000);
		alu_check(alu_add, 0, 0, 23, 1'b1, 32'h9000_0000);
		alu_check(alu_add, 0, 0, 22, 1'b1, $random(seed));
		alu_check(alu_add, 20, 21, 22, 1'b0, '0);	// pos + pos traps
		alu_check(alu_sub, 23, 20, 22, 1'b0, '0);	// neg - pos traps
		alu_check(alu_addu, 22, 0, 24, 1'b0, '0);	// r22 read back unchanged
		alu_check(alu_addu, 20, 21, 25, 1'b0, '0);	// wrapped sum
	endtask

	task automatic muldiv_test();
		md_check(md_mul, 1, 2, 13);
		md_check(md_divu, 3, 4, 14);
		md_check(md_remu, 3, 4, 15);
		md_check(md_divu, 5, 0, 16);	// divide by zero
		md_check(md_remu, 5, 0, 17);
		md_check(md_remu, 1, 27, 19);
	endtask

	task automatic sharing_test();
		alu_op_t     ops [3];
		logic [4:0]  src_a [3];
		logic [4:0]  src_b [3];
		logic [4:0]  dst [3];
		logic [32:0] exp_alu [3];
		logic [31:0] exp_md;
		logic        md_seen;
		int          n;
		int          k;
		ops = '{alu_addu, alu_xor, alu_subu};
		src_a = '{5'd1, 5'd3, 5'd5};
		src_b = '{5'd2, 5'd4, 5'd6};
		dst = '{5'd10, 5'd11, 5'd12};
		for (int i = 0; i < 3; i++) begin
			exp_alu[i] = model_alu(ops[i], model_regs[src_a[i]], model_regs[src_b[i]]);
		end
		exp_md = model_md(md_mul, model_regs[7], model_regs[8]);
		@(posedge clk);
		set_issue(unit_md, alu_addu, md_mul, 7, 8, 13, 1'b0, '0);
		n = 0;
		md_seen = 1'b0;
		while (!(md_seen && !busy) && (n < 100)) begin
			@(posedge clk);
			n++;
			if ((n >= 32) && (n <= 34)) begin	// ALU writes land on md result cycle
				k = n - 32;
				set_issue(unit_alu, ops[k], md_mul, src_a[k], src_b[k], dst[k], 1'b0, '0);
			end else begin
				issue <= 1'b0;
			end
			@(negedge clk);
			if ((n >= 33) && (n <= 35)) begin
				k = n - 33;
				check_value("alu wb_valid", wb_valid, 1'b1);
				check_value("alu wb_addr", wb_addr, dst[k]);
				check_value("alu wb_data", wb_data, exp_alu[k][31:0]);
			end else if (wb_valid) begin
				md_seen = 1'b1;
				check_value("md write cycle", n, 36);	// first free cycle
				check_value("md wb_addr", wb_addr, 13);
				check_value("md wb_data", wb_data, exp_md);
			end
		end
		if (!md_seen || busy) begin
			timeouts++;
			$display("Timeout: multiply/divide result never written under ALU traffic");
		end
		for (int i = 0; i < 3; i++) begin
			model_regs[dst[i]] = exp_alu[i][31:0];
		end
		model_regs[13] = exp_md;
	endtask

	initial begin
		seed = 32'hd902adc2;
		errors = 0;
		timeouts = 0;
		reset = 1'b1;
		issue = 1'b0;
		unit = unit_alu;
		alu_op = alu_add;
		md_op = md_mul;
		rs = '0;
		rt = '0;
		rd = '0;
		use_imm = 1'b0;
		imm = '0;
		for (int i = 0; i < `EXEC_NREGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("busy after reset", busy, 1'b0);
		check_value("wb_valid after reset", wb_valid, 1'b0);
		check_value("overflow after reset", overflow, 1'b0);
		seed_regs();
		arith_test();
		shift_test();
		compare_test();
		overflow_test();
		muldiv_test();
		sharing_test();
		$display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/exec_core_props.sv
`default_nettype none
`include "exec_params.svh"

module exec_core_props (
	input logic                   clk,
	input logic                   reset,
	input logic                   issue,
	input exec_pkg::exec_unit_t   unit,
	input logic [`EXEC_RADDR-1:0] rd,
	input logic                   busy,
	input logic                   wb_valid,
	input logic                   overflow,
	input logic                   md_grant
);
	import exec_pkg::*;

	// a trap replaces the write, never both
	wb_ovf_excl: assert property (@(posedge clk) disable iff (reset)
		!(wb_valid && overflow))
		else $error("wb_valid and overflow high in the same cycle");

	// fixed one-cycle ALU latency
	alu_latency: assert property (@(posedge clk) disable iff (reset)
		(issue && (unit == unit_alu) && (rd != '0)) |=> (wb_valid || overflow))
		else $error("ALU issue without writeback or overflow on the next cycle");

	busy_after_write: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> $past(md_grant && wb_valid))
		else $error("busy fell without a multiply/divide write");

endmodule

bind exec_core exec_core_props u_props (
	.clk      (clk),
	.reset    (reset),
	.issue    (issue),
	.unit     (unit),
	.rd       (rd),
	.busy     (busy),
	.wb_valid (wb_valid),
	.overflow (overflow),
	.md_grant (md_grant)
);

`default_nettype wire

//--- hdl/exec_core.sv
`default_nettype none
`include "exec_params.svh"

module exec_core (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue,
	input  exec_pkg::exec_unit_t   unit,
	input  exec_pkg::alu_op_t      alu_op,
	input  exec_pkg::md_op_t       md_op,
	input  logic [`EXEC_RADDR-1:0] rs,
	input  logic [`EXEC_RADDR-1:0] rt,
	input  logic [`EXEC_RADDR-1:0] rd,
	input  logic                   use_imm,
	input  logic [`EXEC_XLEN-1:0]  imm,
	output logic                   busy,
	output logic                   wb_valid,
	output logic [`EXEC_RADDR-1:0] wb_addr,
	output logic [`EXEC_XLEN-1:0]  wb_data,
	output logic                   overflow
);
	import exec_pkg::*;

	logic [`EXEC_RADDR-1:0] ra1;
	logic [`EXEC_RADDR-1:0] ra2;
	logic [`EXEC_XLEN-1:0]  rd1;
	logic [`EXEC_XLEN-1:0]  rd2;
	logic [`EXEC_XLEN-1:0]  alu_a;
	logic [`EXEC_XLEN-1:0]  alu_b;
	alu_op_t                alu_fn;
	logic [`EXEC_XLEN-1:0]  alu_c;
	logic                   alu_ovf;
	logic                   md_start;
	md_op_t                 md_fn;
	logic [`EXEC_XLEN-1:0]  md_a;
	logic [`EXEC_XLEN-1:0]  md_b;
	logic [`EXEC_RADDR-1:0] md_dest;
	logic                   alu_req;
	logic [`EXEC_RADDR-1:0] alu_addr;
	logic [`EXEC_XLEN-1:0]  alu_data;
	logic                   md_req;
	logic [`EXEC_RADDR-1:0] md_addr;
	logic [`EXEC_XLEN-1:0]  md_data;
	logic                   md_grant;

	reg_file u_reg_file (
		.clk   (clk),
		.reset (reset),
		.ra1   (ra1),
		.ra2   (ra2),
		.rd1   (rd1),
		.rd2   (rd2),
		.we    (wb_valid),	// write port doubles as the writeback report
		.waddr (wb_addr),
		.wdata (wb_data)
	);

	issue_ctrl u_issue_ctrl (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue),
		.unit     (unit),
		.alu_op   (alu_op),
		.md_op    (md_op),
		.rs       (rs),
		.rt       (rt),
		.rd       (rd),
		.use_imm  (use_imm),
		.imm      (imm),
		.ra1      (ra1),
		.ra2      (ra2),
		.rd1      (rd1),
		.rd2      (rd2),
		.alu_a    (alu_a),
		.alu_b    (alu_b),
		.alu_fn   (alu_fn),
		.alu_c    (alu_c),
		.alu_ovf  (alu_ovf),
		.md_start (md_start),
		.md_fn    (md_fn),
		.md_a     (md_a),
		.md_b     (md_b),
		.md_dest  (md_dest),
		.alu_req  (alu_req),
		.alu_addr (alu_addr),
		.alu_data (alu_data),
		.overflow (overflow)
	);

	alu1 u_alu1 (
		.A        (alu_a),
		.B        (alu_b),
		.ALU1Op   (alu_fn),
		.C        (alu_c),
		.Overflow (alu_ovf)
	);

	muldiv_unit u_muldiv_unit (
		.clk      (clk),
		.reset    (reset),
		.md_start (md_start),
		.md_fn    (md_fn),
		.md_a     (md_a),
		.md_b     (md_b),
		.md_dest  (md_dest),
		.md_req   (md_req),
		.md_addr  (md_addr),
		.md_data  (md_data),
		.md_grant (md_grant),
		.busy     (busy)
	);

	wb_arbiter u_wb_arbiter (
		.alu_req  (alu_req),
		.alu_addr (alu_addr),
		.alu_data (alu_data),
		.md_req   (md_req),
		.md_addr  (md_addr),
		.md_data  (md_data),
		.md_grant (md_grant),
		.we       (wb_valid),
		.waddr    (wb_addr),
		.wdata    (wb_data)
	);

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
`default_nettype none
`include "exec_params.svh"

module issue_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue,
	input  exec_pkg::exec_unit_t   unit,
	input  exec_pkg::alu_op_t      alu_op,
	input  exec_pkg::md_op_t       md_op,
	input  logic [`EXEC_RADDR-1:0] rs,
	input  logic [`EXEC_RADDR-1:0] rt,
	input  logic [`EXEC_RADDR-1:0] rd,
	input  logic                   use_imm,
	input  logic [`EXEC_XLEN-1:0]  imm,
	output logic [`EXEC_RADDR-1:0] ra1,
	output logic [`EXEC_RADDR-1:0] ra2,
	input  logic [`EXEC_XLEN-1:0]  rd1,
	input  logic [`EXEC_XLEN-1:0]  rd2,
	output logic [`EXEC_XLEN-1:0]  alu_a,
	output logic [`EXEC_XLEN-1:0]  alu_b,
	output exec_pkg::alu_op_t      alu_fn,
	input  logic [`EXEC_XLEN-1:0]  alu_c,
	input  logic                   alu_ovf,
	output logic                   md_start,
	output exec_pkg::md_op_t       md_fn,
	output logic [`EXEC_XLEN-1:0]  md_a,
	output logic [`EXEC_XLEN-1:0]  md_b,
	output logic [`EXEC_RADDR-1:0] md_dest,
	output logic                   alu_req,
	output logic [`EXEC_RADDR-1:0] alu_addr,
	output logic [`EXEC_XLEN-1:0]  alu_data,
	output logic                   overflow
);
	import exec_pkg::*;

	logic [`EXEC_XLEN-1:0] opnd_b;
	logic                  alu_issue;

	assign ra1       = rs;
	assign ra2       = rt;
	assign opnd_b    = use_imm ? imm : rd2;	// imm arrives already extended
	assign alu_issue = issue && (unit == unit_alu);

	assign alu_a  = rd1;
	assign alu_b  = opnd_b;
	assign alu_fn = alu_op;

	assign md_start = issue && (unit == unit_md);
	assign md_fn    = md_op;
	assign md_a     = rd1;
	assign md_b     = opnd_b;
	assign md_dest  = rd;

	// trap replaces the write
	always_ff @(posedge clk) begin
		if (reset) begin
			alu_req  <= 1'b0;
			overflow <= 1'b0;
		end else begin
			alu_req  <= alu_issue && !alu_ovf && (rd != '0);
			overflow <= alu_issue && alu_ovf;
		end
	end

	always_ff @(posedge clk) begin
		if (alu_issue) begin
			alu_addr <= rd;
			alu_data <= alu_c;
		end
	end

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
`default_nettype none
`include "exec_params.svh"

module wb_arbiter (
	input  logic                   alu_req,
	input  logic [`EXEC_RADDR-1:0] alu_addr,
	input  logic [`EXEC_XLEN-1:0]  alu_data,
	input  logic                   md_req,
	input  logic [`EXEC_RADDR-1:0] md_addr,
	input  logic [`EXEC_XLEN-1:0]  md_data,
	output logic                   md_grant,
	output logic                   we,
	output logic [`EXEC_RADDR-1:0] waddr,
	output logic [`EXEC_XLEN-1:0]  wdata
);

	// fixed priority, the ALU never waits
	assign md_grant = md_req && !alu_req;

	assign waddr = alu_req ? alu_addr : md_addr;
	assign wdata = alu_req ? alu_data : md_data;

	// writes aimed at r0 are not reported
	assign we = (alu_req || md_req) && (waddr != '0);

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
`default_nettype none
`include "exec_params.svh"

module muldiv_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   md_start,
	input  exec_pkg::md_op_t       md_fn,
	input  logic [`EXEC_XLEN-1:0]  md_a,
	input  logic [`EXEC_XLEN-1:0]  md_b,
	input  logic [`EXEC_RADDR-1:0] md_dest,
	output logic                   md_req,
	output logic [`EXEC_RADDR-1:0] md_addr,
	output logic [`EXEC_XLEN-1:0]  md_data,
	input  logic                   md_grant,
	output logic                   busy
);
	import exec_pkg::*;

	localparam int CNT_W = $clog2(`EXEC_MD_STEPS + 1);

	md_state_t              state_q;
	logic [CNT_W-1:0]       cnt_q;
	md_op_t                 op_q;
	logic [`EXEC_RADDR-1:0] dest_q;
	logic [`EXEC_XLEN-1:0]  acc_q;	// product sum or partial remainder
	logic [`EXEC_XLEN-1:0]  x_q;	// multiplicand or dividend/quotient
	logic [`EXEC_XLEN-1:0]  y_q;	// multiplier or divisor
	logic [`EXEC_XLEN-1:0]  res_q;
	logic [`EXEC_XLEN:0]    div_shift;
	logic                   div_ge;
	logic                   last_step;

	// restoring step: bring in next dividend bit, subtract if it fits
	// a zero divisor always fits, so quotient ends all ones, remainder = dividend
	assign div_shift = {acc_q, x_q[`EXEC_XLEN-1]};
	assign div_ge    = div_shift >= {1'b0, y_q};
	assign last_step = (cnt_q == CNT_W'(`EXEC_MD_STEPS));	// extra cycle latches result

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= md_idle;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				md_idle: begin
					if (md_start) begin
						state_q <= md_run;
						cnt_q   <= '0;
					end
				end
				md_run: begin
					cnt_q <= cnt_q + 1'b1;
					if (last_step) begin
						state_q <= (dest_q == '0) ? md_idle : md_hold;	// r0 needs no write
					end
				end
				md_hold: begin
					if (md_grant) begin
						state_q <= md_idle;
					end
				end
				default: state_q <= md_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == md_idle) && md_start) begin
			op_q   <= md_fn;
			dest_q <= md_dest;
			acc_q  <= '0;
			x_q    <= md_a;
			y_q    <= md_b;
		end else if ((state_q == md_run) && !last_step) begin
			if (op_q == md_mul) begin
				if (y_q[0]) begin
					acc_q <= acc_q + x_q;
				end
				x_q <= {x_q[`EXEC_XLEN-2:0], 1'b0};
				y_q <= {1'b0, y_q[`EXEC_XLEN-1:1]};
			end else begin
				acc_q <= div_ge ? (div_shift[`EXEC_XLEN-1:0] - y_q) : div_shift[`EXEC_XLEN-1:0];
				x_q   <= {x_q[`EXEC_XLEN-2:0], div_ge};	// quotient bit in
			end
		end else if (state_q == md_run) begin
			case (op_q)
				md_divu: res_q <= x_q;
				default: res_q <= acc_q;	// product or remainder
			endcase
		end
	end

	assign md_req  = (state_q == md_hold);
	assign md_addr = dest_q;
	assign md_data = res_q;
	assign busy    = (state_q != md_idle);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none
`include "exec_params.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`EXEC_RADDR-1:0] ra1,
	input  logic [`EXEC_RADDR-1:0] ra2,
	output logic [`EXEC_XLEN-1:0]  rd1,
	output logic [`EXEC_XLEN-1:0]  rd2,
	input  logic                   we,
	input  logic [`EXEC_RADDR-1:0] waddr,
	input  logic [`EXEC_XLEN-1:0]  wdata
);

	logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `EXEC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin	// r0 is hardwired
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads, r0 forced to zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- hdl/alu1.sv
`default_nettype none
`include "exec_params.svh"

module alu1 (
	input  logic [`EXEC_XLEN-1:0] A,
	input  logic [`EXEC_XLEN-1:0] B,
	input  exec_pkg::alu_op_t     ALU1Op,
	output logic [`EXEC_XLEN-1:0] C,
	output logic                  Overflow
);
	import exec_pkg::*;

	logic [`EXEC_XLEN-1:0] sum;
	logic [`EXEC_XLEN-1:0] diff;
	logic [4:0]            shamt;
	logic                  lt_signed;
	logic                  lt_unsigned;
	logic                  add_ovf;
	logic                  sub_ovf;

	assign sum         = A + B;
	assign diff        = A - B;
	assign shamt       = A[4:0];	// rs supplies the shift amount
	assign lt_signed   = $signed(A) < $signed(B);
	assign lt_unsigned = A < B;

	// same-sign operands giving a result of the other sign
	assign add_ovf = (A[`EXEC_XLEN-1] == B[`EXEC_XLEN-1]) &&
		(sum[`EXEC_XLEN-1] != A[`EXEC_XLEN-1]);
	// operands of opposite sign, result sign flips away from A
	assign sub_ovf = (A[`EXEC_XLEN-1] != B[`EXEC_XLEN-1]) &&
		(diff[`EXEC_XLEN-1] != A[`EXEC_XLEN-1]);

	always_comb begin
		case (ALU1Op)
			alu_add, alu_addu: C = sum;
			alu_sub, alu_subu: C = diff;
			alu_or:            C = A | B;
			alu_and:           C = A & B;
			alu_nor:           C = ~(A | B);
			alu_xor:           C = A ^ B;
			alu_sll:           C = B << shamt;
			alu_srl:           C = B >> shamt;
			alu_sra:           C = $signed(B) >>> shamt;	// sign fill
			alu_slt:           C = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
			alu_sltu:          C = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
			default:           C = '0;	// unused codes 13..15
		endcase
	end

	always_comb begin
		case (ALU1Op)
			alu_add: Overflow = add_ovf;
			alu_sub: Overflow = sub_ovf;
			default: Overflow = 1'b0;	// unsigned forms never trap
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

	// encodings follow the alu1 opcode map
	typedef enum logic [3:0] {
		alu_add  = 4'd0,	// signed with trap
		alu_sub  = 4'd1,	// signed with trap
		alu_or   = 4'd2,
		alu_and  = 4'd3,
		alu_nor  = 4'd4,
		alu_xor  = 4'd5,
		alu_sll  = 4'd6,
		alu_srl  = 4'd7,
		alu_sra  = 4'd8,
		alu_slt  = 4'd9,
		alu_sltu = 4'd10,
		alu_addu = 4'd11,
		alu_subu = 4'd12
	} alu_op_t;

	typedef enum logic [1:0] {
		md_mul  = 2'd0,	// low word of product
		md_divu = 2'd1,
		md_remu = 2'd2
	} md_op_t;

	typedef enum logic {
		unit_alu = 1'b0,
		unit_md  = 1'b1
	} exec_unit_t;

	typedef enum logic [1:0] {
		md_idle = 2'd0,
		md_run  = 2'd1,
		md_hold = 2'd2	// result waiting for the write port
	} md_state_t;

endpackage

`default_nettype wire

//--- hdl/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define EXEC_XLEN 32		// datapath width
`define EXEC_NREGS 32		// architectural registers
`define EXEC_RADDR 5		// register address bits
`define EXEC_MD_STEPS 32	// one step per operand bit

`endif
